/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f laneExec.f --top-module laneExecTb -o laneExecSim
	./obj_dir/laneExecSim | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* exStage1.sv */
`timescale 1ns/1ns
// Inputs are sampled only at edges with hold low; undefined opcodes leave as disabled ops
module exStage1 import execDefs::*; (
	input logic clock,
	input logic arstN,
	input logic hold,
	input uCmd_t uCmd,
	input logic lastT,
	input logic flush,
	input regId_t rdId,
	input word_t srcA,
	input word_t srcB,
	input word_t imm,
	output logic badOp,
	stageLink.src out
);

	predCode_t predCode;
	opcode_t opcode;
	logic predOk;	// Predicate passes against T
	logic opKnown;	// Opcode is defined
	logic opEnable;
	word_t aluResult;

	assign predCode = uCmd[cmdWidth-1:opWidth];
	assign opcode = uCmd[opWidth-1:0];

	always_comb begin
		case (predCode)
			predAlways: predOk = 1'b1;
			predNever: predOk = 1'b0;
			predIfT: predOk = lastT;
			predIfF: predOk = !lastT;
			default: predOk = 1'b0;
		endcase
	end

	always_comb begin
		opKnown = 1'b1;
		aluResult = '0;
		case (opcode)
			ucNop: aluResult = '0;	// Nothing to write
			ucMovIr: aluResult = imm;
			ucAdd: aluResult = srcA + srcB;
			ucSub: aluResult = srcA - srcB;
			ucAnd: aluResult = srcA & srcB;
			ucOr: aluResult = srcA | srcB;
			ucXor: aluResult = srcA ^ srcB;
			ucMul: aluResult = srcA;	// Multiplicand, product formed in stage two
			ucLoad: aluResult = srcA + imm;	// Effective address
			default: opKnown = 1'b0;
		endcase
	end

	// A nop or killed op still flows down, just with valid low
	assign opEnable = predOk && !flush && opKnown && (opcode != ucNop);
	assign badOp = !hold && predOk && !flush && !opKnown;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			out.valid <= 1'b0;
		else if (!hold)
			out.valid <= opEnable;
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			out.op <= opcode;
			out.rdId <= rdId;
			out.result <= aluResult;
			out.operandB <= srcB;
		end
	end

	// A held op stays at the inputs until the lane takes it
	heldInputsStable: assert property (@(posedge clock) disable iff (!arstN)
		hold |=> $stable({uCmd, lastT, rdId, srcA, srcB, imm}))
		else $error("inputs changed while the lane was held");

endmodule

/* exStage2.sv */
`timescale 1ns/1ns
// Multiply keeps only the low data word; every other op passes through unchanged
module exStage2 import execDefs::*; (
	input logic clock,
	input logic arstN,
	input logic hold,
	stageLink.dst in,
	stageLink.src out
);

	word_t product;
	word_t nextResult;

	assign product = in.result * in.operandB;	// Truncates to the low word
	assign nextResult = (in.op == ucMul) ? product : in.result;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			out.valid <= 1'b0;
		else if (!hold)
			out.valid <= in.valid;
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			out.op <= in.op;
			out.rdId <= in.rdId;
			out.result <= nextResult;
			out.operandB <= in.operandB;	// Unused downstream, kept for a uniform link
		end
	end

endmodule

/* exStage3.sv */
`timescale 1ns/1ns
// Purely combinational; load writeback exists only in a cycle with memReady high
module exStage3 import execDefs::*; (
	stageLink.dst in,
	input logic memReady,
	input word_t memData,
	input logic fault,
	output logic loadPending,
	output logic memRead,
	output word_t memAddr,
	output logic wbValid,
	output regId_t wbId,
	output word_t wbValue
);

	logic isLoad;

	assign isLoad = in.valid && (in.op == ucLoad);

	// Load request straight from the link
	assign loadPending = isLoad;
	assign memRead = isLoad;
	assign memAddr = in.result;

	always_comb begin
		wbId = in.rdId;	// Forward by default
		wbValue = in.result;
		wbValid = in.valid;
		if (isLoad) begin
			wbValue = memData;	// Switch to memory data
			wbValid = memReady && !fault;	// Dropped load writes nothing
		end
	end

	// A timed out load must never retire
	always_comb begin
		noWbOnFault: assert (!(wbValid && fault))
			else $error("writeback during memory fault");
	end

endmodule

/* execDefs.sv */
// Shared constants and types for the execute lane; opcodes above ucLoad are treated as undefined
package execDefs;

	localparam int dataWidth = 32;	// Data word width
	localparam int regIdWidth = 6;	// Register id width
	localparam int cmdWidth = 8;	// Predicate plus opcode
	localparam int opWidth = 6;	// Low part of the command

	localparam int memTimeout = 8;	// Max memRead cycles per load
	localparam int timerWidth = $clog2(memTimeout);	// Counts 0 .. memTimeout-1

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regIdWidth-1:0] regId_t;
	typedef logic [cmdWidth-1:0] uCmd_t;
	typedef logic [opWidth-1:0] opcode_t;
	typedef logic [cmdWidth-opWidth-1:0] predCode_t;
	typedef logic [timerWidth-1:0] waitCount_t;

	// Predicate codes, top two command bits
	localparam predCode_t predAlways = 2'd0;
	localparam predCode_t predNever = 2'd1;
	localparam predCode_t predIfT = 2'd2;
	localparam predCode_t predIfF = 2'd3;

	// Opcodes, low six command bits
	localparam opcode_t ucNop = 6'd0;
	localparam opcode_t ucMovIr = 6'd1;	// Rd = imm
	localparam opcode_t ucAdd = 6'd2;	// Rd = A + B
	localparam opcode_t ucSub = 6'd3;	// Rd = A - B
	localparam opcode_t ucAnd = 6'd4;
	localparam opcode_t ucOr = 6'd5;
	localparam opcode_t ucXor = 6'd6;
	localparam opcode_t ucMul = 6'd7;	// Low word of A * B
	localparam opcode_t ucLoad = 6'd8;	// Rd = mem[A + imm]

	// Front end state while a load sits in stage three
	typedef enum logic {
		stRun,
		stWait
	} holdState_t;

endpackage

/* holdControl.sv */
`timescale 1ns/1ns
// Hold comes only from a load waiting on memory; timeout drops the load without writeback
module holdControl import execDefs::*; (
	input logic clock,
	input logic arstN,
	input logic loadPending,
	input logic memReady,
	input logic timerDone,
	output logic hold,
	output logic memFault,
	output logic timerRun
);

	holdState_t state;
	holdState_t nextState;
	logic loadWait;	// Load present, memory not answering

	assign loadWait = loadPending && !memReady;
	assign timerRun = loadWait;
	assign hold = loadWait && !timerDone;
	assign memFault = (state == stWait) && loadWait && timerDone;	// Timeout pulse

	always_comb begin
		nextState = state;
		case (state)
			stRun: if (loadWait && !timerDone) nextState = stWait;
			stWait: if (!loadWait || timerDone) nextState = stRun;	// Data or timeout
			default: nextState = stRun;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			state <= stRun;
		else
			state <= nextState;
	end

	// Frozen pipeline keeps the load in stage three for the whole wait
	waitKeepsLoad: assert property (@(posedge clock) disable iff (!arstN)
		(state == stWait) |-> loadPending)
		else $error("load vanished while waiting");

endmodule

/* holdTimer.sv */
`timescale 1ns/1ns
// done marks the memTimeout-th consecutive run cycle; any gap in run restarts the count
module holdTimer import execDefs::*; (
	input logic clock,
	input logic arstN,
	input logic run,
	output logic done
);

	waitCount_t count;	// Wait cycles already seen

	assign done = run && (count == waitCount_t'(memTimeout - 1));

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			count <= '0;
		else if (!run || done)
			count <= '0;	// Fresh count for the next load
		else
			count <= count + 1'b1;
	end

endmodule

/* laneExec.f */
execDefs.sv
stageLink.sv
exStage1.sv
exStage2.sv
exStage3.sv
holdControl.sv
holdTimer.sv
laneExec.sv
laneExecTb.sv

/* laneExec.sv */
`timescale 1ns/1ns
// Source must hold its inputs stable while hold is high; one micro-op accepted per free clock
module laneExec import execDefs::*; (
	input logic clock,
	input logic arstN,
	input uCmd_t uCmd,
	input logic lastT,
	input logic flush,
	input regId_t rdId,
	input word_t srcA,
	input word_t srcB,
	input word_t imm,
	input logic memReady,
	input word_t memData,
	output logic hold,
	output logic badOp,
	output logic memRead,
	output word_t memAddr,
	output logic memFault,
	output logic wbValid,
	output regId_t wbId,
	output word_t wbValue
);

	logic loadPending;
	logic timerRun;
	logic timerDone;

	stageLink link12 ();	// EX1 to EX2
	stageLink link23 ();	// EX2 to EX3

	exStage1 ex1 (
		.clock(clock), .arstN(arstN), .hold(hold),
		.uCmd(uCmd), .lastT(lastT), .flush(flush),
		.rdId(rdId), .srcA(srcA), .srcB(srcB), .imm(imm),
		.badOp(badOp), .out(link12.src)
	);

	exStage2 ex2 (
		.clock(clock), .arstN(arstN), .hold(hold),
		.in(link12.dst), .out(link23.src)
	);

	exStage3 ex3 (
		.in(link23.dst), .memReady(memReady), .memData(memData),
		.fault(memFault), .loadPending(loadPending),
		.memRead(memRead), .memAddr(memAddr),
		.wbValid(wbValid), .wbId(wbId), .wbValue(wbValue)
	);

	holdControl holdCtl (
		.clock(clock), .arstN(arstN), .loadPending(loadPending),
		.memReady(memReady), .timerDone(timerDone),
		.hold(hold), .memFault(memFault), .timerRun(timerRun)
	);

	holdTimer waitTimer (
		.clock(clock), .arstN(arstN), .run(timerRun), .done(timerDone)
	);

endmodule

/* laneExecTb.sv */
`timescale 1ns/1ns
// Inputs change on falling edges and outputs are read 2 ns later; memory data is a hash of the address
module laneExecTb import execDefs::*; ();

	logic clock, arstN, lastT, flush, memReady;
	uCmd_t uCmd;
	regId_t rdId, wbId;
	word_t srcA, srcB, imm, memData, memAddr, wbValue;
	logic hold, badOp, memRead, memFault, wbValid;

	integer seed = 94556;
	int edgeCount = 0;	// Rising edges since time zero
	int dueQ[$];	// Edge count at which each writeback shows
	regId_t idQ[$];
	word_t valueQ[$];
	int memDelay;	// memRead cycles without memReady
	int memWait;	// memRead cycles seen for the current load
	int readCycles;	// memRead cycles counted for a test
	int holdCycles;
	int faultCount;
	int faultCycle;	// memRead cycle of the last fault
	logic lastHold;
	logic badOpExpected;
	word_t expAddr;

	laneExec dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
		edgeCount <= edgeCount + 1;

	task automatic failStop(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input string what, input word_t expected,
			input word_t actual);
		assert (actual === expected)
			else failStop($sformatf("FAIL %s %s expected %h actual %h", name, what,
				expected, actual));
	endtask

	function automatic word_t memWord(input word_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;	// Every address bit matters
	endfunction

	// Writeback value from the opcode rules
	function automatic word_t expectAlu(input opcode_t op, input word_t a, input word_t b,
			input word_t i);
		case (op)
			ucMovIr: return i;
			ucAdd: return a + b;
			ucSub: return a - b;
			ucAnd: return a & b;
			ucOr: return a | b;
			ucXor: return a ^ b;
			ucMul: return a * b;	// Low word only
			default: return memWord(a + i);	// Load data
		endcase
	endfunction

	// One cycle: memory answers, outputs get checked, then on to the next falling edge
	task automatic tick(input string name);
		memWait = memRead ? memWait + 1 : 0;
		memReady = memRead && (memWait > memDelay);
		memData = memWord(memAddr);
		#2;
		lastHold = hold;
		holdCycles += int'(hold);
		readCycles += int'(memRead);
		faultCount += int'(memFault);
		if (memFault)
			faultCycle = memWait;
		checkValue(name, "memFault", word_t'(memRead && !memReady && memWait == memTimeout),
			word_t'(memFault));	// Only the last allowed wait cycle faults
		if (memRead)
			checkValue(name, "memAddr", expAddr, memAddr);
		checkValue(name, "badOp", word_t'(badOpExpected), word_t'(badOp));
		if (dueQ.size() > 0 && dueQ[0] == edgeCount) begin
			checkValue(name, "wbValid", 1, word_t'(wbValid));
			checkValue(name, "wbId", word_t'(idQ.pop_front()), word_t'(wbId));
			checkValue(name, "wbValue", valueQ.pop_front(), wbValue);
			void'(dueQ.pop_front());
		end else begin
			checkValue(name, "wbValid", 0, word_t'(wbValid));
		end
		@(negedge clock);
	endtask

	// Present one op until the lane takes it, then queue its writeback if enabled
	task automatic issue(input string name, input uCmd_t cmd, input logic t, input regId_t rd,
			input word_t a, input word_t b, input word_t i, input logic wbExpected, input int extra);
		int tries;
		tries = 0;
		uCmd = cmd;
		lastT = t;
		rdId = rd;
		srcA = a;
		srcB = b;
		imm = i;
		tick(name);
		while (lastHold) begin	// Not taken while a load holds the lane
			tries++;
			assert (tries < 4 * memTimeout) else failStop($sformatf("%s: op never accepted", name));
			tick(name);
		end
		if (wbExpected) begin
			dueQ.push_back(edgeCount + 1 + extra);	// Two edges after acceptance plus wait cycles
			idQ.push_back(rd);
			valueQ.push_back(expectAlu(cmd[opWidth-1:0], a, b, i));
		end
		uCmd = {predAlways, ucNop};
	endtask

	task automatic drain(input string name);
		int n;
		n = 0;
		while (dueQ.size() > 0) begin
			n++;
			assert (n < 30) else failStop($sformatf("%s: expected writeback never came", name));
			tick(name);
		end
		tick(name);	// Spare cycles catch stray writebacks
		tick(name);
	endtask

	task automatic aluTest();
		opcode_t ops[6] = '{ucMovIr, ucAdd, ucSub, ucAnd, ucOr, ucXor};
		foreach (ops[k])
			issue("aluOps", {predAlways, ops[k]}, 1'b0, regId_t'(k + 1), word_t'($random(seed)),
				word_t'($random(seed)), word_t'($random(seed)), 1'b1, 0);
		drain("aluOps");
	endtask

	task automatic mulTest();
		repeat (4)
			issue("multiply", {predAlways, ucMul}, 1'b0, regId_t'($random(seed)),
				word_t'($random(seed)), word_t'($random(seed)), '0, 1'b1, 0);
		drain("multiply");
	endtask

	task automatic predTest();
		logic runs;
		for (int p = 0; p < 4; p++) begin
			for (int t = 0; t < 2; t++) begin
				runs = (p == 0) || (p == 2 && t == 1) || (p == 3 && t == 0);	// Predicate rule
				issue("predicate", {predCode_t'(p), ucAdd}, t[0], regId_t'(2 * p + t),
					word_t'($random(seed)), word_t'($random(seed)), '0, runs, 0);
			end
		end
		flush = 1'b1;	// Flush kills even an always op
		issue("flush", {predAlways, ucAdd}, 1'b0, 6'd9, 32'd1, 32'd2, '0, 1'b0, 0);
		flush = 1'b0;
		drain("predicate");
	endtask

	task automatic loadReadyTest();
		word_t a;
		word_t i;
		a = $random(seed);
		i = $random(seed);
		expAddr = a + i;
		holdCycles = 0;
		readCycles = 0;
		issue("loadReady", {predAlways, ucLoad}, 1'b0, 6'd12, a, '0, i, 1'b1, 0);
		drain("loadReady");
		checkValue("loadReady", "hold cycles", 0, word_t'(holdCycles));
		checkValue("loadReady", "memRead cycles", 1, word_t'(readCycles));
	endtask

	task automatic loadWaitTest();
		word_t a;
		word_t i;
		int n;
		a = $random(seed);
		i = $random(seed);
		expAddr = a + i;
		memDelay = 3;	// Ready on the fourth memRead cycle
		holdCycles = 0;
		readCycles = 0;
		issue("loadWait", {predAlways, ucLoad}, 1'b0, 6'd20, a, '0, i, 1'b1, 3);
		issue("loadWait", {predAlways, ucAdd}, 1'b0, 6'd21, a, i, '0, 1'b1, 3);	// Rides the hold
		issue("loadWait", {predAlways, ucSub}, 1'b0, 6'd22, a, i, '0, 1'b1, 0);	// Waits at inputs
		drain("loadWait");
		checkValue("loadWait", "hold cycles", 3, word_t'(holdCycles));
		checkValue("loadWait", "memRead cycles", 4, word_t'(readCycles));
		memDelay = 1000;	// Memory never answers
		faultCount = 0;
		readCycles = 0;
		issue("loadTimeout", {predAlways, ucLoad}, 1'b0, 6'd23, a, '0, i, 1'b0, 0);
		n = 0;
		while (faultCount == 0) begin
			n++;
			assert (n < 4 * memTimeout) else failStop("loadTimeout: memFault never pulsed");
			tick("loadTimeout");
		end
		drain("loadTimeout");
		checkValue("loadTimeout", "memFault pulses", 1, word_t'(faultCount));
		checkValue("loadTimeout", "memFault cycle", memTimeout, word_t'(faultCycle));
		checkValue("loadTimeout", "memRead cycles", memTimeout, word_t'(readCycles));
		memDelay = 0;
	endtask

	task automatic badOpTest();
		issue("undefinedOp", {predAlways, ucAdd}, 1'b0, 6'd30, 32'd5, 32'd7, '0, 1'b1, 0);
		badOpExpected = 1'b1;
		issue("undefinedOp", {predAlways, 6'h2A}, 1'b0, 6'd31, 32'd5, 32'd7, '0, 1'b0, 0);
		badOpExpected = 1'b0;
		issue("undefinedOp", {predAlways, ucXor}, 1'b0, 6'd32, 32'd5, 32'd7, '0, 1'b1, 0);
		drain("undefinedOp");
	endtask

	initial begin
		arstN = 1'b0;
		uCmd = {predAlways, ucNop};
		lastT = 1'b0;
		flush = 1'b0;
		rdId = '0;
		srcA = '0;
		srcB = '0;
		imm = '0;
		memReady = 1'b0;
		memData = '0;
		memDelay = 0;
		memWait = 0;
		readCycles = 0;
		holdCycles = 0;
		faultCount = 0;
		faultCycle = 0;
		lastHold = 1'b0;
		badOpExpected = 1'b0;
		expAddr = '0;
		repeat (10) @(negedge clock);	// Reset cycles
		checkValue("reset", "status outputs", '0,
			word_t'({wbValid, memRead, hold, memFault, badOp}));
		arstN = 1'b1;
		aluTest();
		mulTest();
		predTest();
		loadReadyTest();
		loadWaitTest();
		badOpTest();
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* stageLink.sv */
`timescale 1ns/1ns
// One registered stage result; result holds the address for loads and operandB is only read for multiply
interface stageLink import execDefs::*; ();

	logic valid;	// Op enabled and defined
	opcode_t op;	// Opcode after decode
	regId_t rdId;	// Destination register
	word_t result;	// ALU result or load address
	word_t operandB;	// Source B for the multiplier

	modport src (
		output valid,
		output op,
		output rdId,
		output result,
		output operandB
	);

	modport dst (
		input valid,
		input op,
		input rdId,
		input result,
		input operandB
	);

endinterface
